//--- flist.f
rtl/axi_perf_pkg.sv
rtl/perf_regs.sv
rtl/axi_write_gen.sv
rtl/sram_axi_writer.sv
rtl/axi_perf_sram.sv
sim/tb_clock.sv
sim/sram_model.sv
sim/axi_perf_sram_assert.sv
sim/axi_perf_sram_tb.sv

//--- rtl/axi_perf_pkg.sv
`default_nettype none

package axi_perf_pkg;

  localparam int SRAM_ADDR_WIDTH = 20;
  localparam int SRAM_DATA_WIDTH = 16;
  localparam int AXI_ADDR_WIDTH = SRAM_ADDR_WIDTH + 1;
  localparam int AXI_DATA_WIDTH = SRAM_DATA_WIDTH;
  localparam int AXI_STRB_WIDTH = 2;
  localparam int AXI_ID_WIDTH = 4;
  localparam int MAX_BURST_LEN = 16;
  localparam int LEN_WIDTH = $clog2(MAX_BURST_LEN) + 1;  // holds 1 to 16.
  localparam int COUNT_WIDTH = 8;
  localparam int CNT_WIDTH = 32;
  localparam int CMD_VALUE_WIDTH = 32;

  localparam logic [AXI_ID_WIDTH-1:0] GEN_ID = 4'h1;
  localparam logic [2:0] AXI_SIZE_WORD = 3'($clog2(AXI_STRB_WIDTH));
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef enum logic [2:0] {
    CMD_SET_BASE,
    CMD_SET_LEN,
    CMD_SET_COUNT,
    CMD_SET_PATTERN,
    CMD_START
  } cmd_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef struct packed {
    cmd_op_e                    op;
    logic [CMD_VALUE_WIDTH-1:0] value;
  } perf_cmd_t;

  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0]  base;     // byte address.
    logic [LEN_WIDTH-1:0]       len;      // beats per burst.
    logic [COUNT_WIDTH-1:0]     count;
    logic [SRAM_DATA_WIDTH-1:0] pattern;
  } perf_cfg_t;

  typedef struct packed {
    logic [CNT_WIDTH-1:0] cycles;
    logic [CNT_WIDTH-1:0] bursts;
    logic [CNT_WIDTH-1:0] errors;
  } perf_result_t;

  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [7:0]                len;
    logic [2:0]                size;
    logic [1:0]                burst;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0] id;
    axi_resp_e               resp;
  } axi_b_t;

endpackage

`default_nettype wire

//--- rtl/axi_perf_sram.sv
`default_nettype none

module axi_perf_sram (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cmd_valid,
  input  axi_perf_pkg::perf_cmd_t                  cmd,
  output logic                                     cmd_ready,
  output axi_perf_pkg::perf_result_t               result,
  output logic                                     result_valid,
  output logic [axi_perf_pkg::SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [axi_perf_pkg::SRAM_DATA_WIDTH-1:0] sram_data,
  output logic                                     sram_we_n,
  output logic                                     sram_oe_n,
  output logic                                     sram_ce_n
);
  import axi_perf_pkg::*;

  logic         start;
  perf_cfg_t    cfg;
  logic         busy;
  logic         done;
  perf_result_t gen_result;

  logic         aw_valid;
  axi_aw_t      aw;
  logic         aw_ready;
  logic         w_valid;
  axi_w_t       w;
  logic         w_ready;
  logic         b_valid;
  axi_b_t       b;
  logic         b_ready;

  perf_regs perf_regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_ready   (cmd_ready),
    .start       (start),
    .cfg         (cfg),
    .busy        (busy),
    .done        (done),
    .gen_result  (gen_result),
    .result      (result),
    .result_valid(result_valid)
  );

  axi_write_gen axi_write_gen_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .cfg     (cfg),
    .busy    (busy),
    .done    (done),
    .result  (gen_result),
    .aw_valid(aw_valid),
    .aw      (aw),
    .aw_ready(aw_ready),
    .w_valid (w_valid),
    .w       (w),
    .w_ready (w_ready),
    .b_valid (b_valid),
    .b       (b),
    .b_ready (b_ready)
  );

  sram_axi_writer sram_axi_writer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n)
  );

endmodule

`default_nettype wire

//--- rtl/axi_write_gen.sv
`default_nettype none

module axi_write_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  axi_perf_pkg::perf_cfg_t    cfg,
  output logic                       busy,
  output logic                       done,
  output axi_perf_pkg::perf_result_t result,
  output logic                       aw_valid,
  output axi_perf_pkg::axi_aw_t      aw,
  input  logic                       aw_ready,
  output logic                       w_valid,
  output axi_perf_pkg::axi_w_t       w,
  input  logic                       w_ready,
  input  logic                       b_valid,
  input  axi_perf_pkg::axi_b_t       b,
  output logic                       b_ready
);
  import axi_perf_pkg::*;

  typedef enum logic [1:0] {
    AW_IDLE,
    AW_LOAD,
    AW_SEND
  } aw_state_e;

  aw_state_e                  aw_state;
  logic [COUNT_WIDTH-1:0]     aw_left;
  logic [AXI_ADDR_WIDTH:0]    aw_next;  // spare top bit marks a start past the last word.
  logic [AXI_ADDR_WIDTH:0]    burst_bytes;
  logic [SRAM_ADDR_WIDTH-1:0] load_word;
  logic                       q_valid;
  logic                       q_push;
  logic                       q_pop;
  logic [SRAM_ADDR_WIDTH-1:0] q_word;
  logic [LEN_WIDTH-1:0]       w_left;
  logic [SRAM_ADDR_WIDTH-1:0] w_word;
  logic                       b_fire;
  logic                       last_resp;

  assign burst_bytes = {{(AXI_ADDR_WIDTH - LEN_WIDTH){1'b0}}, cfg.len, 1'b0};

  // bursts starting beyond memory are pinned to the top word so they never wrap.
  assign load_word = aw_next[AXI_ADDR_WIDTH] ? '1 : aw_next[AXI_ADDR_WIDTH-1:1];

  assign q_push   = (aw_state == AW_LOAD) && (aw_left != '0) && !q_valid;
  assign q_pop    = q_valid && !w_valid;
  assign aw_valid = (aw_state == AW_SEND);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_state <= AW_IDLE;
      aw_left  <= '0;
      aw_next  <= '0;
    end else begin
      case (aw_state)
        AW_IDLE: begin
          if (start) begin
            aw_left  <= cfg.count;
            aw_next  <= {1'b0, cfg.base};
            aw_state <= AW_LOAD;
          end
        end
        AW_LOAD: begin
          if (aw_left == '0) begin
            aw_state <= AW_IDLE;
          end else if (q_push) begin
            aw_left  <= aw_left - 1'b1;
            aw_next  <= aw_next + burst_bytes;
            aw_state <= AW_SEND;
          end
        end
        AW_SEND: if (aw_ready) aw_state <= AW_LOAD;
        default: aw_state <= AW_IDLE;
      endcase
    end
  end

  // one pending burst between address issue and beat sequencing.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_valid <= 1'b0;
      w_valid <= 1'b0;
      w_left  <= '0;
    end else begin
      if (q_push) begin
        q_valid <= 1'b1;
      end else if (q_pop) begin
        q_valid <= 1'b0;
      end

      if (q_pop) begin
        w_valid <= 1'b1;
        w_left  <= cfg.len;
      end else if (w_valid && w_ready) begin
        w_valid <= !w.last;
        w_left  <= w_left - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (q_push) begin
      aw.addr  <= {load_word, 1'b0};
      aw.id    <= GEN_ID;
      aw.len   <= 8'(cfg.len) - 8'd1;
      aw.size  <= AXI_SIZE_WORD;
      aw.burst <= AXI_BURST_INCR;
      q_word   <= load_word;
    end
    if (q_pop) begin
      w_word <= q_word;
    end else if (w_valid && w_ready) begin
      w_word <= w_word + 1'b1;
    end
  end

  assign w.data = w_word[SRAM_DATA_WIDTH-1:0] + cfg.pattern;  // address plus pattern.
  assign w.strb = '1;
  assign w.last = (w_left == LEN_WIDTH'(1));

  assign b_ready   = 1'b1;
  assign b_fire    = b_valid && b_ready;
  assign last_resp = (result.bursts + CNT_WIDTH'(1)) == CNT_WIDTH'(cfg.count);

  // start cycle counts as the first one.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy          <= 1'b1;
        result.cycles <= CNT_WIDTH'(1);
        result.bursts <= '0;
        result.errors <= '0;
      end else if (busy) begin
        result.cycles <= result.cycles + 1'b1;
        if (b_fire) begin
          result.bursts <= result.bursts + 1'b1;
          if (b.resp == RESP_SLVERR) result.errors <= result.errors + 1'b1;
          if (last_resp) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/perf_regs.sv
`default_nettype none

module perf_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  axi_perf_pkg::perf_cmd_t    cmd,
  output logic                       cmd_ready,
  output logic                       start,
  output axi_perf_pkg::perf_cfg_t    cfg,
  input  logic                       busy,
  input  logic                       done,
  input  axi_perf_pkg::perf_result_t gen_result,
  output axi_perf_pkg::perf_result_t result,
  output logic                       result_valid
);
  import axi_perf_pkg::*;

  logic cmd_fire;
  logic start_fire;

  // nothing is taken from the start pulse until the result is latched.
  assign cmd_ready  = !(start || busy || done);
  assign cmd_fire   = cmd_valid && cmd_ready;
  assign start_fire = cmd_fire && (cmd.op == CMD_START);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg          <= '{base: '0, len: LEN_WIDTH'(1), count: COUNT_WIDTH'(1), pattern: '0};
      start        <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      start <= start_fire;

      if (done) begin
        result_valid <= 1'b1;
      end else if (start_fire) begin
        result_valid <= 1'b0;
      end

      if (cmd_fire) begin
        case (cmd.op)
          CMD_SET_BASE: cfg.base <= cmd.value[AXI_ADDR_WIDTH-1:0];
          CMD_SET_LEN: begin
            // clamped to 1..16 beats.
            if (cmd.value == '0) begin
              cfg.len <= LEN_WIDTH'(1);
            end else if (cmd.value > CMD_VALUE_WIDTH'(MAX_BURST_LEN)) begin
              cfg.len <= LEN_WIDTH'(MAX_BURST_LEN);
            end else begin
              cfg.len <= cmd.value[LEN_WIDTH-1:0];
            end
          end
          CMD_SET_COUNT: begin
            if (cmd.value == '0) begin
              cfg.count <= COUNT_WIDTH'(1);
            end else if (cmd.value > CMD_VALUE_WIDTH'(2 ** COUNT_WIDTH - 1)) begin
              cfg.count <= '1;
            end else begin
              cfg.count <= cmd.value[COUNT_WIDTH-1:0];
            end
          end
          CMD_SET_PATTERN: cfg.pattern <= cmd.value[SRAM_DATA_WIDTH-1:0];
          default: ;  // start handled above.
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      result <= gen_result;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sram_axi_writer.sv
`default_nettype none

module sram_axi_writer (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     aw_valid,
  input  axi_perf_pkg::axi_aw_t                    aw,
  output logic                                     aw_ready,
  input  logic                                     w_valid,
  input  axi_perf_pkg::axi_w_t                     w,
  output logic                                     w_ready,
  output logic                                     b_valid,
  output axi_perf_pkg::axi_b_t                     b,
  input  logic                                     b_ready,
  output logic [axi_perf_pkg::SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [axi_perf_pkg::SRAM_DATA_WIDTH-1:0] sram_data,
  output logic                                     sram_we_n,
  output logic                                     sram_oe_n,
  output logic                                     sram_ce_n
);
  import axi_perf_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_STROBE,
    WR_RESP
  } wr_state_e;

  wr_state_e                  state;
  logic [SRAM_ADDR_WIDTH:0]   word;         // extra bit set once past the top word.
  logic [SRAM_ADDR_WIDTH:0]   aw_end_word;
  logic [SRAM_DATA_WIDTH-1:0] sram_wdata;
  logic                       last_q;
  logic                       write_ok;

  assign aw_ready = (state == WR_IDLE);
  assign w_ready  = (state == WR_DATA);
  assign b_valid  = (state == WR_RESP);

  assign aw_end_word = {1'b0, aw.addr[AXI_ADDR_WIDTH-1:1]} +
                       {{(SRAM_ADDR_WIDTH - 7){1'b0}}, aw.len};
  assign write_ok    = !word[SRAM_ADDR_WIDTH] && (w.strb != '0);

  // output enable stays off without a read path.
  assign sram_oe_n = 1'b1;
  assign sram_data = sram_we_n ? 'z : sram_wdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= WR_IDLE;
      sram_we_n <= 1'b1;
      sram_ce_n <= 1'b1;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_valid) begin
            state     <= WR_DATA;
            sram_ce_n <= 1'b0;  // selected for the whole burst.
          end
        end
        WR_DATA: begin
          if (w_valid) begin
            sram_we_n <= !write_ok;
            state     <= WR_STROBE;
          end
        end
        WR_STROBE: begin
          sram_we_n <= 1'b1;
          state     <= last_q ? WR_RESP : WR_DATA;
        end
        WR_RESP: begin
          if (b_ready) begin
            state     <= WR_IDLE;
            sram_ce_n <= 1'b1;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      word   <= {1'b0, aw.addr[AXI_ADDR_WIDTH-1:1]};
      b.id   <= aw.id;
      // any beat beyond the top word fails the whole burst.
      b.resp <= aw_end_word[SRAM_ADDR_WIDTH] ? RESP_SLVERR : RESP_OKAY;
    end else if (state == WR_STROBE) begin
      word <= word + 1'b1;
    end
    if (w_valid && w_ready) begin
      sram_addr  <= word[SRAM_ADDR_WIDTH-1:0];
      sram_wdata <= w.data;
      last_q     <= w.last;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module axi_perf_sram_tb -f flist.f

output=$(./obj_dir/Vaxi_perf_sram_tb 2>&1) || true
echo "$output"

if grep -q "^Done: no errors$" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- sim/axi_perf_sram_assert.sv
`default_nettype none

module axi_perf_sram_assert (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  aw_valid,
  input axi_perf_pkg::axi_aw_t aw,
  input logic                  aw_ready,
  input logic                  w_valid,
  input axi_perf_pkg::axi_w_t  w,
  input logic                  w_ready,
  input logic                  b_valid,
  input axi_perf_pkg::axi_b_t  b,
  input logic                  b_ready,
  input logic                  sram_we_n,
  input logic                  sram_oe_n,
  input logic                  sram_ce_n
);

  no_bus_fight: assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram_we_n && !sram_oe_n))
    else $error("write enable and output enable both active");

  aw_held: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else $error("aw payload changed while stalled");

  w_held: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else $error("w payload changed while stalled");

  b_held: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b payload changed while stalled");

  // chip select covers every write strobe.
  ce_on_write: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n |-> !sram_ce_n)
    else $error("write strobe without chip enable");

endmodule

bind sram_axi_writer axi_perf_sram_assert writer_checks (.*);

`default_nettype wire

//--- sim/axi_perf_sram_tb.sv
`default_nettype none

module axi_perf_sram_tb;
  import axi_perf_pkg::*;

  // worst-case beats summed over every run of every test.
  localparam int WORST_BEATS    = 1 + 16 * 8 + 2 * 16 * 4 + 16 * 4 + 5 * 16 * 8;
  localparam int TIMEOUT_CYCLES = 4 * WORST_BEATS + 2000;

  logic                       clk;
  logic                       rst_n;
  logic                       cmd_valid;
  perf_cmd_t                  cmd;
  logic                       cmd_ready;
  perf_result_t               result;
  logic                       result_valid;
  logic [SRAM_ADDR_WIDTH-1:0] sram_addr;
  wire  [SRAM_DATA_WIDTH-1:0] sram_data;
  logic                       sram_we_n;
  logic                       sram_oe_n;
  logic                       sram_ce_n;

  integer                     seed;
  int unsigned                cycle_count = 0;
  logic [SRAM_DATA_WIDTH-1:0] first_pattern;  // word 0 keeps it after the first test.

  tb_clock clock_gen (.clk(clk));

  axi_perf_sram UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_ready   (cmd_ready),
    .result      (result),
    .result_valid(result_valid),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_ce_n   (sram_ce_n)
  );

  sram_model sram (
    .addr(sram_addr),
    .data(sram_data),
    .we_n(sram_we_n),
    .ce_n(sram_ce_n)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a run never finished", cycle_count);
      $display("Done: errors found");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  task automatic stop_on_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  // cycles in exp is the lower bound of two cycles per beat.
  task automatic check_result(input perf_result_t got, input perf_result_t exp,
                              input string what);
    if (got.bursts !== exp.bursts) begin
      stop_on_error($sformatf("%s: bursts %0d, expected %0d", what, got.bursts, exp.bursts));
    end
    if (got.errors !== exp.errors) begin
      stop_on_error($sformatf("%s: errors %0d, expected %0d", what, got.errors, exp.errors));
    end
    if (got.cycles < exp.cycles) begin
      stop_on_error($sformatf("%s: cycles %0d, expected at least %0d", what, got.cycles,
                              exp.cycles));
    end
  endtask

  task automatic check_word(input logic [SRAM_ADDR_WIDTH-1:0] addr,
                            input logic [SRAM_DATA_WIDTH-1:0] exp, input string what);
    logic [SRAM_DATA_WIDTH-1:0] got;
    if (!sram.written(addr)) begin
      stop_on_error($sformatf("%s: word %05h never written", what, addr));
    end
    got = sram.read_word(addr);
    if (got !== exp) begin
      stop_on_error($sformatf("%s: word %05h is %04h, expected %04h", what, addr, got, exp));
    end
  endtask

  task automatic send_cmd(input cmd_op_e op, input logic [CMD_VALUE_WIDTH-1:0] value);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd       = '{op: op, value: value};
    while (!cmd_ready) @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic configure_run(input logic [AXI_ADDR_WIDTH-1:0] base, input int len,
                               input int count, input logic [SRAM_DATA_WIDTH-1:0] pattern);
    send_cmd(CMD_SET_BASE, 32'(base));
    send_cmd(CMD_SET_LEN, 32'(len));
    send_cmd(CMD_SET_COUNT, 32'(count));
    send_cmd(CMD_SET_PATTERN, 32'(pattern));
  endtask

  task automatic start_and_wait(output perf_result_t res);
    send_cmd(CMD_START, '0);
    while (!result_valid) @(negedge clk);
    res = result;
  endtask

  // each beat lands at word address plus pattern; words past the top are skipped.
  task automatic check_run_words(input logic [AXI_ADDR_WIDTH-1:0] base, input int len,
                                 input int count, input logic [SRAM_DATA_WIDTH-1:0] pattern,
                                 input string what);
    logic [SRAM_ADDR_WIDTH:0] a;
    for (int k = 0; k < count; k++) begin
      for (int i = 0; i < len; i++) begin
        a = {1'b0, base[AXI_ADDR_WIDTH-1:1]} + 21'(k * len + i);
        if (!a[SRAM_ADDR_WIDTH]) check_word(a[SRAM_ADDR_WIDTH-1:0], a[15:0] + pattern, what);
      end
    end
  endtask

  task automatic test_single_burst();
    perf_result_t res;
    if (!cmd_ready || result_valid || !sram_we_n || !sram_oe_n || !sram_ce_n) begin
      stop_on_error("outputs not in their reset state");
    end
    first_pattern = 16'($random(seed));
    send_cmd(CMD_SET_PATTERN, 32'(first_pattern));  // base 0, one beat, one burst.
    start_and_wait(res);
    check_result(res, '{cycles: 32'd2, bursts: 32'd1, errors: '0}, "single burst");
    check_word('0, first_pattern, "single burst");
  endtask

  task automatic test_multi_burst();
    perf_result_t               res;
    logic [SRAM_ADDR_WIDTH-1:0] word;
    logic [SRAM_DATA_WIDTH-1:0] pat;
    word = 20'h100 + 20'($random(seed) & 32'h3ffff);
    pat  = 16'($random(seed));
    configure_run({word, 1'b0}, 16, 8, pat);
    start_and_wait(res);
    check_result(res, '{cycles: 32'(2 * 16 * 8), bursts: 32'd8, errors: '0}, "multi burst");
    check_run_words({word, 1'b0}, 16, 8, pat, "multi burst");
  endtask

  task automatic test_command_blocking();
    perf_result_t               res;
    logic [SRAM_DATA_WIDTH-1:0] old_pat;
    logic [SRAM_DATA_WIDTH-1:0] new_pat;
    old_pat = 16'($random(seed));
    new_pat = ~old_pat;
    configure_run(21'h4000, 16, 4, old_pat);
    send_cmd(CMD_START, '0);
    cmd_valid = 1'b1;  // pattern change offered mid-run.
    cmd       = '{op: CMD_SET_PATTERN, value: 32'(new_pat)};
    while (!result_valid) begin
      if (cmd_ready) stop_on_error("cmd_ready high while a run is busy");
      @(negedge clk);
    end
    res = result;
    check_result(res, '{cycles: 32'(2 * 16 * 4), bursts: 32'd4, errors: '0}, "blocked run");
    check_run_words(21'h4000, 16, 4, old_pat, "blocked run");
    @(negedge clk);
    cmd_valid = 1'b0;
    send_cmd(CMD_SET_BASE, 32'h6000);
    start_and_wait(res);
    check_result(res, '{cycles: 32'(2 * 16 * 4), bursts: 32'd4, errors: '0}, "after block");
    check_run_words(21'h6000, 16, 4, new_pat, "after block");
  endtask

  task automatic test_top_bound();
    perf_result_t               res;
    logic [SRAM_DATA_WIDTH-1:0] pat;
    logic [AXI_ADDR_WIDTH-1:0]  base;
    pat  = 16'($random(seed));
    base = {20'hfffd7, 1'b0};  // bursts 2 and 3 run past the top word.
    configure_run(base, 16, 4, pat);
    start_and_wait(res);
    check_result(res, '{cycles: 32'(2 * 16 * 4), bursts: 32'd4, errors: 32'd2}, "top bound");
    check_run_words(base, 16, 4, pat, "top bound");
    check_word('0, first_pattern, "low word");
    for (int a = 1; a < 16; a++) begin
      if (sram.written(20'(a))) stop_on_error($sformatf("low word %0d written by a wrap", a));
    end
  endtask

  task automatic test_random_runs();
    perf_result_t               res;
    logic [SRAM_ADDR_WIDTH-1:0] word;
    logic [SRAM_DATA_WIDTH-1:0] pat;
    int                         len;
    int                         count;
    for (int r = 0; r < 5; r++) begin
      word  = 20'h100 + 20'($random(seed) & 32'h3ffff);
      len   = 1 + ($random(seed) & 15);
      count = 1 + ($random(seed) & 7);
      pat   = 16'($random(seed));
      configure_run({word, 1'b0}, len, count, pat);
      start_and_wait(res);
      check_result(res, '{cycles: 32'(2 * len * count), bursts: 32'(count), errors: '0},
                   $sformatf("random run %0d", r));
      check_run_words({word, 1'b0}, len, count, pat, $sformatf("random run %0d", r));
    end
  endtask

  initial begin
    seed      = 69;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '{op: CMD_SET_BASE, value: '0};
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    test_single_burst();
    test_multi_burst();
    test_command_blocking();
    test_top_bound();
    test_random_runs();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/sram_model.sv
`default_nettype none

module sram_model (
  input logic [axi_perf_pkg::SRAM_ADDR_WIDTH-1:0] addr,
  input wire  [axi_perf_pkg::SRAM_DATA_WIDTH-1:0] data,
  input logic                                     we_n,
  input logic                                     ce_n
);
  import axi_perf_pkg::*;

  // only written words exist.
  logic [SRAM_DATA_WIDTH-1:0] mem [logic [SRAM_ADDR_WIDTH-1:0]];

  always @(negedge we_n) begin
    #1;  // address and data settle inside the pulse.
    if (!ce_n && !we_n) begin
      mem[addr] = data;
    end
  end

  function automatic logic written(input logic [SRAM_ADDR_WIDTH-1:0] a);
    return mem.exists(a) != 0;
  endfunction

  function automatic logic [SRAM_DATA_WIDTH-1:0] read_word(
    input logic [SRAM_ADDR_WIDTH-1:0] a
  );
    return mem[a];
  endfunction

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk
);
  localparam int HALF_PERIOD = 2;  // period of 4.

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire
